/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_fetch_mem
FILELIST  := sim.f
LOG       := sim.log

SRCS := $(shell grep -v '^+' $(FILELIST)) fetch_mem_consts.svh
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "TEST OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* cache_array_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface cache_array_if;

  fetch_mem_pkg::line_idx_t rd_idx;
  fetch_mem_pkg::line_tag_t rd_tag;
  fetch_mem_pkg::mem_word_t rd_data;
  logic                     rd_hit;

  // Line fill
  logic                     wr_en;
  fetch_mem_pkg::line_idx_t wr_idx;
  fetch_mem_pkg::line_tag_t wr_tag;
  fetch_mem_pkg::mem_word_t wr_data;

  modport ctrl (
    output rd_idx,
    output rd_tag,
    input  rd_data,
    input  rd_hit,
    output wr_en,
    output wr_idx,
    output wr_tag,
    output wr_data
  );

  modport array (
    input  rd_idx,
    input  rd_tag,
    output rd_data,
    output rd_hit,
    input  wr_en,
    input  wr_idx,
    input  wr_tag,
    input  wr_data
  );

endinterface

`default_nettype wire

/* fetch_mem_consts.svh */
`ifndef FETCH_MEM_CONSTS_SVH
`define FETCH_MEM_CONSTS_SVH

// Direct-mapped instruction cache geometry
`define ICACHE_LINES 32
`define IDX_BITS 5
`define TAG_BITS 8
`define BLOCK_OFFSET_BITS 3   // 8-byte blocks

// Memory transaction tags, zero means no tag
`define MEM_TAG_BITS 4

// Wait cycles before a lost load is sent again
`define MISS_TIMEOUT 64

`endif

/* fetch_mem_pkg.sv */
`default_nettype none

`include "fetch_mem_consts.svh"

package fetch_mem_pkg;

  typedef logic [63:0] mem_addr_t;   // Byte address
  typedef logic [63:0] mem_word_t;   // One cache block
  typedef logic [`MEM_TAG_BITS-1:0] mem_tag_t;
  typedef logic [`IDX_BITS-1:0] line_idx_t;
  typedef logic [`TAG_BITS-1:0] line_tag_t;

  // Wide enough to hold the full timeout value
  typedef logic [$clog2(`MISS_TIMEOUT + 1)-1:0] wait_count_t;

  typedef enum logic [1:0] {
    BUS_NONE  = 2'h0,
    BUS_LOAD  = 2'h1,
    BUS_STORE = 2'h2
  } bus_cmd_e;

  typedef enum logic [1:0] {
    IDLE      = 2'h0,
    REQUEST   = 2'h1,
    WAIT_DATA = 2'h2
  } icache_state_e;

endpackage

`default_nettype wire

/* fetch_mem_top.sv */
`timescale 1ns/1ns
`default_nettype none

module fetch_mem_top (
  input  wire logic                     clock,
  input  wire logic                     arst_n,
  input  wire fetch_mem_pkg::mem_addr_t fetch_addr,
  input  wire fetch_mem_pkg::bus_cmd_e  dmem_command,
  input  wire fetch_mem_pkg::mem_addr_t dmem_addr,
  input  wire fetch_mem_pkg::mem_word_t dmem_data,
  input  wire fetch_mem_pkg::mem_tag_t  mem2proc_response,
  input  wire fetch_mem_pkg::mem_tag_t  mem2proc_tag,
  input  wire fetch_mem_pkg::mem_word_t mem2proc_data,
  output fetch_mem_pkg::mem_word_t      fetch_data,
  output logic                          fetch_valid,
  output fetch_mem_pkg::mem_tag_t       dmem_response,
  output fetch_mem_pkg::mem_tag_t       dmem_tag,
  output fetch_mem_pkg::bus_cmd_e       proc2mem_command,
  output fetch_mem_pkg::mem_addr_t      proc2mem_addr,
  output fetch_mem_pkg::mem_word_t      proc2mem_data
);

  mem_port_if    imem_port ();
  cache_array_if icache_arr ();

  icache_mem u_icache_mem (
    .clock  (clock),
    .arst_n (arst_n),
    .arr    (icache_arr)
  );

  icache_ctrl u_icache_ctrl (
    .clock       (clock),
    .arst_n      (arst_n),
    .fetch_addr  (fetch_addr),
    .fetch_data  (fetch_data),
    .fetch_valid (fetch_valid),
    .arr         (icache_arr),
    .mem         (imem_port)
  );

  // Single memory port shared with the data side
  mem_bus_arbiter u_mem_bus_arbiter (
    .clock             (clock),
    .arst_n            (arst_n),
    .imem              (imem_port),
    .dmem_command      (dmem_command),
    .dmem_addr         (dmem_addr),
    .dmem_data         (dmem_data),
    .dmem_response     (dmem_response),
    .dmem_tag          (dmem_tag),
    .mem2proc_response (mem2proc_response),
    .mem2proc_tag      (mem2proc_tag),
    .mem2proc_data     (mem2proc_data),
    .proc2mem_command  (proc2mem_command),
    .proc2mem_addr     (proc2mem_addr),
    .proc2mem_data     (proc2mem_data)
  );

endmodule

`default_nettype wire

/* icache_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

`include "fetch_mem_consts.svh"

module icache_ctrl (
  input  wire logic                     clock,
  input  wire logic                     arst_n,
  input  wire fetch_mem_pkg::mem_addr_t fetch_addr,
  output fetch_mem_pkg::mem_word_t      fetch_data,
  output logic                          fetch_valid,
  cache_array_if.ctrl                   arr,
  mem_port_if.requester                 mem
);

  fetch_mem_pkg::icache_state_e state;
  fetch_mem_pkg::icache_state_e state_next;

  fetch_mem_pkg::line_idx_t fetch_idx;
  fetch_mem_pkg::line_tag_t fetch_tag;

  // Outstanding load
  fetch_mem_pkg::mem_tag_t  pend_mem_tag;
  fetch_mem_pkg::line_idx_t fill_idx;
  fetch_mem_pkg::line_tag_t fill_tag;

  logic issuing;
  logic accepted;
  logic reply_match;
  logic timer_on;
  logic timed_out;

  assign fetch_idx = fetch_addr[`BLOCK_OFFSET_BITS +: `IDX_BITS];
  assign fetch_tag = fetch_addr[`BLOCK_OFFSET_BITS + `IDX_BITS +: `TAG_BITS];

  assign arr.rd_idx  = fetch_idx;
  assign arr.rd_tag  = fetch_tag;
  assign fetch_data  = arr.rd_data;
  assign fetch_valid = arr.rd_hit;

  // Request tracks the current address and drops out once it hits
  assign issuing     = (state == fetch_mem_pkg::REQUEST) && !arr.rd_hit;
  assign accepted    = issuing && (mem.response != '0);
  assign reply_match = (state == fetch_mem_pkg::WAIT_DATA) && (mem.reply_tag == pend_mem_tag);

  assign mem.cmd  = issuing ? fetch_mem_pkg::BUS_LOAD : fetch_mem_pkg::BUS_NONE;
  assign mem.addr = {fetch_addr[63:`BLOCK_OFFSET_BITS], {`BLOCK_OFFSET_BITS{1'b0}}};

  assign arr.wr_en   = reply_match;
  assign arr.wr_idx  = fill_idx;
  assign arr.wr_tag  = fill_tag;
  assign arr.wr_data = mem.reply_data;

  // Acceptance cycle counts as the first waiting cycle
  assign timer_on = accepted || (state == fetch_mem_pkg::WAIT_DATA);

  miss_timer u_miss_timer (
    .clock    (clock),
    .arst_n   (arst_n),
    .counting (timer_on),
    .expired  (timed_out)
  );

  always_comb begin
    state_next = state;
    case (state)
      fetch_mem_pkg::IDLE: begin
        if (!arr.rd_hit) state_next = fetch_mem_pkg::REQUEST;
      end
      fetch_mem_pkg::REQUEST: begin
        if (arr.rd_hit) begin
          state_next = fetch_mem_pkg::IDLE;
        end else if (accepted) begin
          state_next = fetch_mem_pkg::WAIT_DATA;
        end
      end
      fetch_mem_pkg::WAIT_DATA: begin
        if (reply_match) begin
          state_next = fetch_mem_pkg::IDLE;   // Line written at this edge
        end else if (timed_out) begin
          state_next = fetch_mem_pkg::REQUEST;
        end
      end
      default: state_next = fetch_mem_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      state <= fetch_mem_pkg::IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_ff @(posedge clock) begin
    if (accepted) begin
      pend_mem_tag <= mem.response;
      fill_idx     <= fetch_idx;
      fill_tag     <= fetch_tag;
    end
  end

endmodule

`default_nettype wire

/* icache_mem.sv */
`timescale 1ns/1ns
`default_nettype none

`include "fetch_mem_consts.svh"

module icache_mem (
  input wire logic     clock,
  input wire logic     arst_n,
  cache_array_if.array arr
);

  fetch_mem_pkg::mem_word_t data_mem [`ICACHE_LINES];
  fetch_mem_pkg::line_tag_t tag_mem  [`ICACHE_LINES];
  logic [`ICACHE_LINES-1:0] line_valid;

  fetch_mem_pkg::line_tag_t stored_tag;
  logic                     tag_match;

  // Valid bits start clear, so stale tags never hit
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      line_valid <= '0;
    end else if (arr.wr_en) begin
      line_valid[arr.wr_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (arr.wr_en) begin
      data_mem[arr.wr_idx] <= arr.wr_data;
      tag_mem[arr.wr_idx]  <= arr.wr_tag;
    end
  end

  // Lookup is combinational
  assign stored_tag = tag_mem[arr.rd_idx];
  assign tag_match  = (stored_tag == arr.rd_tag);

  assign arr.rd_hit  = line_valid[arr.rd_idx] && tag_match;
  assign arr.rd_data = data_mem[arr.rd_idx];

endmodule

`default_nettype wire

/* mem_bus_arbiter.sv */
`timescale 1ns/1ns
`default_nettype none

`include "fetch_mem_consts.svh"

module mem_bus_arbiter (
  input  wire logic                     clock,
  input  wire logic                     arst_n,
  mem_port_if.bus                       imem,
  input  wire fetch_mem_pkg::bus_cmd_e  dmem_command,
  input  wire fetch_mem_pkg::mem_addr_t dmem_addr,
  input  wire fetch_mem_pkg::mem_word_t dmem_data,
  output fetch_mem_pkg::mem_tag_t       dmem_response,
  output fetch_mem_pkg::mem_tag_t       dmem_tag,
  input  wire fetch_mem_pkg::mem_tag_t  mem2proc_response,
  input  wire fetch_mem_pkg::mem_tag_t  mem2proc_tag,
  input  wire fetch_mem_pkg::mem_word_t mem2proc_data,
  output fetch_mem_pkg::bus_cmd_e       proc2mem_command,
  output fetch_mem_pkg::mem_addr_t      proc2mem_addr,
  output fetch_mem_pkg::mem_word_t      proc2mem_data
);

  localparam int TAG_SLOTS = (1 << `MEM_TAG_BITS) - 1;

  // One bit per nonzero tag, set when the data side owns it
  logic [TAG_SLOTS:1] owned_by_d;

  logic d_grant;
  logic bus_accept;
  logic reply_valid;
  logic reply_to_d;

  assign d_grant = (dmem_command != fetch_mem_pkg::BUS_NONE);   // Data side always wins

  assign proc2mem_command = d_grant ? dmem_command : imem.cmd;
  assign proc2mem_addr    = d_grant ? dmem_addr : imem.addr;
  assign proc2mem_data    = d_grant ? dmem_data : '0;   // Fetches never store

  // Refused side sees zero
  assign dmem_response = d_grant ? mem2proc_response : '0;
  assign imem.response = d_grant ? '0 : mem2proc_response;

  assign bus_accept = (proc2mem_command != fetch_mem_pkg::BUS_NONE) &&
                      (mem2proc_response != '0);

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      owned_by_d <= '0;
    end else if (bus_accept) begin
      owned_by_d[mem2proc_response] <= d_grant;
    end
  end

  assign reply_valid = (mem2proc_tag != '0);
  assign reply_to_d  = reply_valid && owned_by_d[mem2proc_tag];

  assign dmem_tag        = reply_to_d ? mem2proc_tag : '0;
  assign imem.reply_tag  = reply_to_d ? '0 : mem2proc_tag;
  assign imem.reply_data = mem2proc_data;

endmodule

`default_nettype wire

/* mem_port_if.sv */
`timescale 1ns/1ns
`default_nettype none

// One requester's view of the shared memory bus
interface mem_port_if;

  fetch_mem_pkg::bus_cmd_e  cmd;
  fetch_mem_pkg::mem_addr_t addr;
  fetch_mem_pkg::mem_tag_t  response;    // Tag of accepted request, zero if refused
  fetch_mem_pkg::mem_tag_t  reply_tag;   // Nonzero in the cycle data returns
  fetch_mem_pkg::mem_word_t reply_data;

  modport requester (
    output cmd,
    output addr,
    input  response,
    input  reply_tag,
    input  reply_data
  );

  modport bus (
    input  cmd,
    input  addr,
    output response,
    output reply_tag,
    output reply_data
  );

endinterface

`default_nettype wire

/* miss_timer.sv */
`timescale 1ns/1ns
`default_nettype none

`include "fetch_mem_consts.svh"

module miss_timer (
  input  wire logic clock,
  input  wire logic arst_n,
  input  wire logic counting,
  output logic      expired
);

  fetch_mem_pkg::wait_count_t count;

  // Cycles counted before the current one
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      count <= '0;
    end else if (!counting || expired) begin
      count <= '0;   // Restart clean for a reissued load
    end else begin
      count <= count + 1'b1;
    end
  end

  // Current cycle is the MISS_TIMEOUT-th one counted
  assign expired = counting &&
                   (count == fetch_mem_pkg::wait_count_t'(`MISS_TIMEOUT - 1));

endmodule

`default_nettype wire

/* sim.f */
+incdir+.
fetch_mem_pkg.sv
mem_port_if.sv
cache_array_if.sv
icache_mem.sv
miss_timer.sv
icache_ctrl.sv
mem_bus_arbiter.sv
fetch_mem_top.sv
tb_clock_gen.sv
tb_fetch_mem.sv

/* tb_clock_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 5
) (
  output logic clock,
  output logic arst_n
);

  initial begin
    clock = 1'b0;
    forever #(PERIOD_NS / 2) clock = ~clock;
  end

  // Release on a falling edge, away from the DUT's sampling edge
  initial begin
    arst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clock);
    @(negedge clock);
    arst_n = 1'b1;
  end

endmodule

`default_nettype wire

/* tb_fetch_mem.sv */
`timescale 1ns/1ns
`default_nettype none

`include "fetch_mem_consts.svh"

module tb_fetch_mem;

  localparam int WAIT_LIMIT = 3 * `MISS_TIMEOUT;
  localparam int TEST_CYCLES = `MISS_TIMEOUT + 6 + 50;   // Timeout, longest delay, settle
  localparam int WATCHDOG_NS = 2 * 6 * TEST_CYCLES * 40;

  logic clock;
  logic arst_n;

  fetch_mem_pkg::mem_addr_t fetch_addr = '0;
  fetch_mem_pkg::bus_cmd_e  dmem_command = fetch_mem_pkg::BUS_NONE;
  fetch_mem_pkg::mem_addr_t dmem_addr = '0;
  fetch_mem_pkg::mem_word_t dmem_data = '0;
  fetch_mem_pkg::mem_tag_t  mem2proc_response = '0;
  fetch_mem_pkg::mem_tag_t  mem2proc_tag = '0;
  fetch_mem_pkg::mem_word_t mem2proc_data = '0;
  fetch_mem_pkg::mem_word_t fetch_data;
  logic                     fetch_valid;
  fetch_mem_pkg::mem_tag_t  dmem_response;
  fetch_mem_pkg::mem_tag_t  dmem_tag;
  fetch_mem_pkg::bus_cmd_e  proc2mem_command;
  fetch_mem_pkg::mem_addr_t proc2mem_addr;
  fetch_mem_pkg::mem_word_t proc2mem_data;

  // Memory model state
  int                      cycle = 0;
  fetch_mem_pkg::mem_tag_t next_tag = 4'd1;
  logic [15:1]             d_owner = '0;
  int                      rq_due[$];
  fetch_mem_pkg::mem_tag_t rq_tag[$];
  fetch_mem_pkg::mem_word_t rq_data[$];
  bit drop_next = 1'b0;
  int inst_loads = 0;
  int last_accept = 0;
  int prev_accept = 0;
  int d_replies = 0;
  fetch_mem_pkg::mem_tag_t exp_dmem_tag = '0;

  // Check strobes and snapshots, changed on falling edges only
  bit fill_chk = 0;
  bit hit_window = 0;
  bit evict_miss_chk = 0;
  bit evict_chk = 0;
  bit route_hold = 0;
  bit route_chk = 0;
  bit to_chk = 0;
  int count_snap = 0;
  int gap_snap = 0;
  int errors = 0;

  tb_clock_gen clk_gen (.clock(clock), .arst_n(arst_n));

  fetch_mem_top uut (
    .clock(clock), .arst_n(arst_n), .fetch_addr(fetch_addr),
    .dmem_command(dmem_command), .dmem_addr(dmem_addr), .dmem_data(dmem_data),
    .mem2proc_response(mem2proc_response), .mem2proc_tag(mem2proc_tag),
    .mem2proc_data(mem2proc_data), .fetch_data(fetch_data), .fetch_valid(fetch_valid),
    .dmem_response(dmem_response), .dmem_tag(dmem_tag),
    .proc2mem_command(proc2mem_command), .proc2mem_addr(proc2mem_addr),
    .proc2mem_data(proc2mem_data)
  );

  // Block address in the low half, its inverse above
  function automatic fetch_mem_pkg::mem_word_t block_word(input fetch_mem_pkg::mem_addr_t a);
    fetch_mem_pkg::mem_addr_t blk;
    blk = {a[63:3], 3'b000};
    return {~blk[31:0], blk[31:0]};
  endfunction

  function automatic fetch_mem_pkg::mem_addr_t rand_block();
    return fetch_mem_pkg::mem_addr_t'($urandom & 32'h0000_fff8);
  endfunction

  // Accepts every command with the next tag
  always @(posedge clock) begin
    if (arst_n && proc2mem_command != fetch_mem_pkg::BUS_NONE) begin
      d_owner[mem2proc_response] = (dmem_command != fetch_mem_pkg::BUS_NONE);
      if (dmem_command == fetch_mem_pkg::BUS_NONE) begin
        inst_loads++;
        prev_accept = last_accept;
        last_accept = cycle;
      end
      if (proc2mem_command == fetch_mem_pkg::BUS_LOAD) begin
        if (drop_next && dmem_command == fetch_mem_pkg::BUS_NONE) begin
          drop_next = 1'b0;   // Lost reply
        end else begin
          rq_due.push_back(cycle + int'($urandom_range(6, 2)));
          rq_tag.push_back(mem2proc_response);
          rq_data.push_back(block_word(proc2mem_addr));
        end
      end
      next_tag = (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
    end
    cycle++;
  end

  // At most one reply per cycle
  always @(negedge clock) begin
    int found;
    found = -1;
    for (int i = 0; i < rq_due.size(); i++) begin
      if (found < 0 && rq_due[i] <= cycle) found = i;
    end
    mem2proc_response = next_tag;
    if (found >= 0) begin
      mem2proc_tag  = rq_tag[found];
      mem2proc_data = rq_data[found];
      exp_dmem_tag  = d_owner[rq_tag[found]] ? rq_tag[found] : '0;
      if (exp_dmem_tag != '0) d_replies++;
      rq_due.delete(found);
      rq_tag.delete(found);
      rq_data.delete(found);
    end else begin
      mem2proc_tag = '0;
      exp_dmem_tag = '0;
    end
  end

  miss_fill: assert property (@(posedge clock) disable iff (!arst_n)
    (fill_chk -> count_snap == 1) && (fetch_valid -> fetch_data == block_word(fetch_addr)))
  else begin
    errors++;
    if (fill_chk) $display("FAILED miss_fill expected 1 load actual %0d", count_snap);
    else $display("FAILED miss_fill expected %h actual %h",
                  block_word(fetch_addr), $sampled(fetch_data));
  end

  hit: assert property (@(posedge clock) disable iff (!arst_n)
    hit_window |-> fetch_valid && proc2mem_command == fetch_mem_pkg::BUS_NONE)
  else begin
    errors++;
    $display("FAILED hit expected valid 1 cmd 0 actual valid %0b cmd %0d",
             $sampled(fetch_valid), $sampled(proc2mem_command));
  end

  conflict_eviction: assert property (@(posedge clock) disable iff (!arst_n)
    (evict_miss_chk -> !fetch_valid) && (evict_chk -> count_snap == 1))
  else begin
    errors++;
    if (evict_chk) $display("FAILED conflict_eviction expected 1 reload actual %0d", count_snap);
    else $display("FAILED conflict_eviction expected valid 0 actual 1");
  end

  data_priority: assert property (@(posedge clock) disable iff (!arst_n)
    dmem_command != fetch_mem_pkg::BUS_NONE |->
      proc2mem_command == dmem_command && proc2mem_addr == dmem_addr &&
      proc2mem_data == dmem_data && dmem_response == mem2proc_response)
  else begin
    errors++;
    $display("FAILED data_priority expected %0d %h %h %0d actual %0d %h %h %0d",
             dmem_command, dmem_addr, dmem_data, mem2proc_response,
             $sampled(proc2mem_command), $sampled(proc2mem_addr),
             $sampled(proc2mem_data), $sampled(dmem_response));
  end

  tag_routing: assert property (@(posedge clock) disable iff (!arst_n)
    (dmem_tag == exp_dmem_tag) && (route_hold -> !fetch_valid) &&
    (route_chk -> count_snap > 0))
  else begin
    errors++;
    if (route_chk) $display("tag_routing: no data-side reply was seen");
    else if (route_hold && $sampled(fetch_valid))
      $display("FAILED tag_routing expected valid 0 actual 1");
    else $display("FAILED tag_routing expected %0d actual %0d", exp_dmem_tag, $sampled(dmem_tag));
  end

  timeout_reissue: assert property (@(posedge clock) disable iff (!arst_n)
    to_chk |-> gap_snap == `MISS_TIMEOUT)
  else begin
    errors++;
    $display("FAILED timeout_reissue expected %0d actual %0d", `MISS_TIMEOUT, gap_snap);
  end

  task automatic wait_fetch();
    int n;
    n = 0;
    do begin
      @(negedge clock);
      n++;
    end while (!fetch_valid && n < WAIT_LIMIT);
    if (!fetch_valid) begin
      errors++;
      $display("fetch of %h never became valid", fetch_addr);
    end
  endtask

  task automatic report_test(input string name, input int err_start);
    $display("%s: done, %0d errors", name, errors - err_start);
  endtask

  initial begin
    int e;
    int base;
    fetch_mem_pkg::mem_addr_t a;
    void'($urandom(12));
    a = rand_block();
    @(posedge arst_n);
    wait_fetch();   // Block zero loads after reset

    e = errors;
    base = inst_loads;
    fetch_addr = a;
    wait_fetch();
    count_snap = inst_loads - base;
    fill_chk = 1;
    @(negedge clock);
    fill_chk = 0;
    report_test("miss_fill", e);

    e = errors;
    hit_window = 1;
    repeat (8) @(negedge clock);
    hit_window = 0;
    report_test("hit", e);

    e = errors;
    fetch_addr = a ^ 64'h0100;
    wait_fetch();
    base = inst_loads;
    fetch_addr = a;
    evict_miss_chk = 1;
    @(negedge clock);
    evict_miss_chk = 0;
    wait_fetch();
    count_snap = inst_loads - base;
    evict_chk = 1;
    @(negedge clock);
    evict_chk = 0;
    report_test("conflict_eviction", e);

    e = errors;
    fetch_addr = a ^ 64'h0200;
    for (int i = 0; i < 6; i++) begin
      dmem_command = (i % 2) ? fetch_mem_pkg::BUS_LOAD : fetch_mem_pkg::BUS_STORE;
      dmem_addr = rand_block();
      dmem_data = {$urandom, $urandom};
      @(negedge clock);
    end
    dmem_command = fetch_mem_pkg::BUS_NONE;
    wait_fetch();
    report_test("data_priority", e);

    e = errors;
    base = d_replies;
    drop_next = 1'b1;   // Fetch stays pending while data replies pass
    fetch_addr = a ^ 64'h0400;
    route_hold = 1;
    repeat (2) @(negedge clock);
    dmem_command = fetch_mem_pkg::BUS_LOAD;
    for (int i = 0; i < 16; i++) begin   // Data side reuses the fetch's tag
      dmem_addr = rand_block();
      @(negedge clock);
    end
    dmem_command = fetch_mem_pkg::BUS_NONE;
    repeat (7) @(negedge clock);   // Let the last data replies drain
    route_hold = 0;
    count_snap = d_replies - base;
    route_chk = 1;
    @(negedge clock);
    route_chk = 0;
    wait_fetch();
    report_test("tag_routing", e);

    e = errors;
    drop_next = 1'b1;
    fetch_addr = a ^ 64'h0800;
    wait_fetch();
    gap_snap = last_accept - prev_accept;
    to_chk = 1;
    @(negedge clock);
    to_chk = 0;
    report_test("timeout_reissue", e);

    $display("6 tests run, %0d errors", errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired before the tests finished");
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire
